//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Word and register file geometry
    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // Fixed unit latencies, the multiplier's comes from MUL_STAGES
    localparam int ALU_LAT   = 1;
    localparam int SHIFT_LAT = 2;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LI,
        OP_SLL, OP_SRL, OP_SRA, OP_MUL
    } opcode_t;

    // Result bus port numbers
    typedef enum logic [1:0] {
        FU_ALU   = 2'd0,
        FU_SHIFT = 2'd1,
        FU_MUL   = 2'd2,
        FU_SPARE = 2'd3
    } fu_t;

endpackage

`default_nettype wire

//--- logic/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit import exec_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  opcode_t           op,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    input  logic [REG_AW-1:0] dest,
    output logic [DATA_W-1:0] result,
    output logic [REG_AW-1:0] result_dest,
    output logic              result_valid
);

    logic [DATA_W-1:0] alu_out;

    always_comb begin
        case (op)
            OP_ADD:  alu_out = operand_a + operand_b;
            OP_SUB:  alu_out = operand_a - operand_b;
            OP_AND:  alu_out = operand_a & operand_b;
            OP_OR:   alu_out = operand_a | operand_b;
            OP_XOR:  alu_out = operand_a ^ operand_b;
            // Immediate already sits on operand_b
            OP_LI:   alu_out = operand_b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= start;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result      <= alu_out;
            result_dest <= dest;
        end
    end

endmodule

`default_nettype wire

//--- logic/shift_unit.sv
`timescale 1ns/1ns
`default_nettype none

module shift_unit import exec_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  opcode_t           op,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    input  logic [REG_AW-1:0] dest,
    output logic [DATA_W-1:0] result,
    output logic [REG_AW-1:0] result_dest,
    output logic              result_valid
);

    // Stage 1 holds the captured operands
    logic              s1_valid;
    opcode_t           s1_op;
    logic [DATA_W-1:0] s1_data;
    logic [4:0]        s1_amount;
    logic [REG_AW-1:0] s1_dest;
    logic [DATA_W-1:0] shifted;

    always_comb begin
        case (s1_op)
            OP_SLL:  shifted = s1_data << s1_amount;
            OP_SRL:  shifted = s1_data >> s1_amount;
            OP_SRA:  shifted = $signed(s1_data) >>> s1_amount;
            default: shifted = s1_data;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= start;
            result_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_op     <= op;
            s1_data   <= operand_a;
            s1_amount <= operand_b[4:0];
            s1_dest   <= dest;
        end
        if (s1_valid) begin
            result      <= shifted;
            result_dest <= s1_dest;
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit import exec_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  opcode_t           op,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    input  logic [REG_AW-1:0] dest,
    output logic [DATA_W-1:0] result,
    output logic [REG_AW-1:0] result_dest,
    output logic              result_valid
);

    logic [MUL_STAGES-1:0] valid_pipe;
    logic [DATA_W-1:0]     prod_pipe [MUL_STAGES];
    logic [REG_AW-1:0]     dest_pipe [MUL_STAGES];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= start && (op == OP_MUL);
            for (int i = 1; i < MUL_STAGES; i++)
                valid_pipe[i] <= valid_pipe[i - 1];
        end
    end

    // Low word of the product is formed up front and later stages only carry it
    always_ff @(posedge clk) begin
        prod_pipe[0] <= operand_a * operand_b;
        dest_pipe[0] <= dest;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_pipe[i] <= prod_pipe[i - 1];
            dest_pipe[i] <= dest_pipe[i - 1];
        end
    end

    assign result       = prod_pipe[MUL_STAGES-1];
    assign result_dest  = dest_pipe[MUL_STAGES-1];
    assign result_valid = valid_pipe[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- logic/cdb.sv
`timescale 1ns/1ns
`default_nettype none

module cdb import exec_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] fu0_data,
    input  logic [REG_AW-1:0] fu0_dest,
    input  logic              fu0_valid,
    input  logic [DATA_W-1:0] fu1_data,
    input  logic [REG_AW-1:0] fu1_dest,
    input  logic              fu1_valid,
    input  logic [DATA_W-1:0] fu2_data,
    input  logic [REG_AW-1:0] fu2_dest,
    input  logic              fu2_valid,
    input  logic [DATA_W-1:0] fu3_data,
    input  logic [REG_AW-1:0] fu3_dest,
    input  logic              fu3_valid,
    // Owner of this cycle's result slot
    input  fu_t               issue_fu_select,
    output logic [REG_AW-1:0] prf_dest,
    output logic [DATA_W-1:0] prf_data,
    output logic              prf_write_enable
);

    logic [DATA_W-1:0] sel_data;
    logic [REG_AW-1:0] sel_dest;
    logic              sel_valid;

    always_comb begin
        case (issue_fu_select)
            FU_ALU: begin
                sel_data  = fu0_data;
                sel_dest  = fu0_dest;
                sel_valid = fu0_valid;
            end
            FU_SHIFT: begin
                sel_data  = fu1_data;
                sel_dest  = fu1_dest;
                sel_valid = fu1_valid;
            end
            FU_MUL: begin
                sel_data  = fu2_data;
                sel_dest  = fu2_dest;
                sel_valid = fu2_valid;
            end
            default: begin
                sel_data  = fu3_data;
                sel_dest  = fu3_dest;
                sel_valid = fu3_valid;
            end
        endcase
    end

    // Data and dest hold their last value when nothing is written
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prf_dest         <= '0;
            prf_data         <= '0;
            prf_write_enable <= 1'b0;
        end else begin
            prf_write_enable <= sel_valid;
            if (sel_valid) begin
                prf_dest <= sel_dest;
                prf_data <= sel_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import exec_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [REG_AW-1:0] rs1_addr,
    input  logic [REG_AW-1:0] rs2_addr,
    input  logic [REG_AW-1:0] dbg_addr,
    output logic [DATA_W-1:0] rs1_data,
    output logic [DATA_W-1:0] rs2_data,
    output logic [DATA_W-1:0] dbg_data,
    input  logic              prf_write_enable,
    input  logic [REG_AW-1:0] prf_dest,
    input  logic [DATA_W-1:0] prf_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Every register starts at zero, none is hardwired
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (prf_write_enable) begin
            regs[prf_dest] <= prf_data;
        end
    end

    // No write-through, a reader sees the new value the cycle after the write
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

//--- logic/issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

module issue_unit import exec_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  opcode_t           instr_op,
    input  logic [REG_AW-1:0] instr_dest,
    input  logic [REG_AW-1:0] instr_src1,
    input  logic [REG_AW-1:0] instr_src2,
    input  logic [DATA_W-1:0] instr_imm,
    output logic              instr_stall,
    output logic [REG_AW-1:0] rs1_addr,
    output logic [REG_AW-1:0] rs2_addr,
    input  logic [DATA_W-1:0] rs1_data,
    input  logic [DATA_W-1:0] rs2_data,
    output logic              alu_start,
    output logic              shift_start,
    output logic              mul_start,
    output opcode_t           op,
    output logic [DATA_W-1:0] operand_a,
    output logic [DATA_W-1:0] operand_b,
    output logic [REG_AW-1:0] dest,
    output fu_t               issue_fu_select,
    input  logic              prf_write_enable,
    input  logic [REG_AW-1:0] prf_dest
);

    localparam int MAX_LAT = (MUL_STAGES > SHIFT_LAT) ? MUL_STAGES : SHIFT_LAT;
    // Entry 0 is the slot the CDB is muxing this cycle
    localparam int DEPTH = MAX_LAT + 1;

    logic [NUM_REGS-1:0] busy;
    logic [DEPTH-1:0]    slot_v;
    fu_t  [DEPTH-1:0]    slot_fu;
    logic [DEPTH-1:0]    slot_v_shift;
    fu_t                 issue_fu;
    int                  issue_lat;
    logic                src_hazard;
    logic                slot_conflict;
    logic                accept;

    assign rs1_addr = instr_src1;
    assign rs2_addr = instr_src2;

    always_comb begin
        case (instr_op)
            OP_SLL, OP_SRL, OP_SRA: begin
                issue_fu  = FU_SHIFT;
                issue_lat = SHIFT_LAT;
            end
            OP_MUL: begin
                issue_fu  = FU_MUL;
                issue_lat = MUL_STAGES;
            end
            default: begin
                issue_fu  = FU_ALU;
                issue_lat = ALU_LAT;
            end
        endcase
    end

    // View of the slot register after this edge's shift
    assign slot_v_shift = {1'b0, slot_v[DEPTH-1:1]};

    // LI reads no register
    assign src_hazard    = (instr_op != OP_LI) && (busy[instr_src1] || busy[instr_src2]);
    assign slot_conflict = slot_v_shift[issue_lat];
    assign instr_stall   = instr_valid && (src_hazard || busy[instr_dest] || slot_conflict);
    assign accept        = instr_valid && !instr_stall;

    assign issue_fu_select = slot_fu[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= '0;
            slot_v      <= '0;
            slot_fu     <= {DEPTH{FU_SPARE}};
            alu_start   <= 1'b0;
            shift_start <= 1'b0;
            mul_start   <= 1'b0;
        end else begin
            // A register is never set and cleared at the same edge, the dest check stalls that
            if (prf_write_enable)
                busy[prf_dest] <= 1'b0;
            if (accept)
                busy[instr_dest] <= 1'b1;

            slot_v <= slot_v_shift;
            for (int i = 0; i < DEPTH - 1; i++)
                slot_fu[i] <= slot_fu[i + 1];
            slot_fu[DEPTH-1] <= FU_SPARE;
            // Reserved entry reaches the head as the unit's result comes out
            if (accept) begin
                slot_v[issue_lat]  <= 1'b1;
                slot_fu[issue_lat] <= issue_fu;
            end

            alu_start   <= accept && (issue_fu == FU_ALU);
            shift_start <= accept && (issue_fu == FU_SHIFT);
            mul_start   <= accept && (issue_fu == FU_MUL);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op        <= instr_op;
            operand_a <= rs1_data;
            operand_b <= (instr_op == OP_LI) ? instr_imm : rs2_data;
            dest      <= instr_dest;
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core import exec_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  opcode_t           instr_op,
    input  logic [REG_AW-1:0] instr_dest,
    input  logic [REG_AW-1:0] instr_src1,
    input  logic [REG_AW-1:0] instr_src2,
    input  logic [DATA_W-1:0] instr_imm,
    output logic              instr_stall,
    input  logic [REG_AW-1:0] dbg_addr,
    output logic [DATA_W-1:0] dbg_data,
    output logic              prf_write_enable,
    output logic [REG_AW-1:0] prf_dest,
    output logic [DATA_W-1:0] prf_data
);

    logic [REG_AW-1:0] rs1_addr, rs2_addr;
    logic [DATA_W-1:0] rs1_data, rs2_data;
    logic              alu_start, shift_start, mul_start;
    opcode_t           op;
    logic [DATA_W-1:0] operand_a, operand_b;
    logic [REG_AW-1:0] dest;
    fu_t               issue_fu_select;

    logic [DATA_W-1:0] alu_result, shift_result, mul_result;
    logic [REG_AW-1:0] alu_dest, shift_dest, mul_dest;
    logic              alu_valid, shift_valid, mul_valid;

    issue_unit #(.MUL_STAGES(MUL_STAGES)) u_issue (
        .clk, .reset,
        .instr_valid, .instr_op, .instr_dest, .instr_src1, .instr_src2, .instr_imm,
        .instr_stall,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .alu_start, .shift_start, .mul_start,
        .op, .operand_a, .operand_b, .dest,
        .issue_fu_select,
        .prf_write_enable, .prf_dest
    );

    alu_unit u_alu (
        .clk, .reset, .start(alu_start), .op, .operand_a, .operand_b, .dest,
        .result(alu_result), .result_dest(alu_dest), .result_valid(alu_valid)
    );

    shift_unit u_shift (
        .clk, .reset, .start(shift_start), .op, .operand_a, .operand_b, .dest,
        .result(shift_result), .result_dest(shift_dest), .result_valid(shift_valid)
    );

    mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul (
        .clk, .reset, .start(mul_start), .op, .operand_a, .operand_b, .dest,
        .result(mul_result), .result_dest(mul_dest), .result_valid(mul_valid)
    );

    // Port 3 is left free for a fourth unit
    cdb u_cdb (
        .clk, .reset,
        .fu0_data(alu_result),   .fu0_dest(alu_dest),   .fu0_valid(alu_valid),
        .fu1_data(shift_result), .fu1_dest(shift_dest), .fu1_valid(shift_valid),
        .fu2_data(mul_result),   .fu2_dest(mul_dest),   .fu2_valid(mul_valid),
        .fu3_data('0),           .fu3_dest('0),         .fu3_valid(1'b0),
        .issue_fu_select,
        .prf_dest, .prf_data, .prf_write_enable
    );

    reg_file u_regs (
        .clk, .reset,
        .rs1_addr, .rs2_addr, .dbg_addr,
        .rs1_data, .rs2_data, .dbg_data,
        .prf_write_enable, .prf_dest, .prf_data
    );

endmodule

`default_nettype wire

//--- bench/exec_core_assert.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core_assert import exec_pkg::*; (
    input logic clk,
    input logic reset,
    input logic fu0_valid,
    input logic fu1_valid,
    input logic fu2_valid,
    input logic fu3_valid,
    input fu_t  issue_fu_select,
    input logic prf_write_enable
);

    logic [3:0] fu_valid;

    assign fu_valid = {fu3_valid, fu2_valid, fu1_valid, fu0_valid};

    // Slot reservation lets only one unit drive the bus
    bus_exclusive: assert property (@(posedge clk) disable iff (reset) $onehot0(fu_valid))
        else $error("more than one unit result is valid in the same cycle");

    select_matches: assert property (@(posedge clk) disable iff (reset)
        (|fu_valid) |-> fu_valid[issue_fu_select])
        else $error("a unit result is valid but the selected port is idle");

    no_write_in_reset: assert property (@(posedge clk) reset |-> !prf_write_enable)
        else $error("register file write enabled during reset");

endmodule

bind cdb exec_core_assert u_assert (
    .clk, .reset,
    .fu0_valid, .fu1_valid, .fu2_valid, .fu3_valid,
    .issue_fu_select, .prf_write_enable
);

`default_nettype wire

//--- bench/exec_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb import exec_pkg::*; ();

    localparam int MUL_STAGES = 3;
    // Upper bound on the instructions issued over all phases
    localparam int NUM_INSTR = 440;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + 200;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    opcode_t           instr_op;
    logic [REG_AW-1:0] instr_dest;
    logic [REG_AW-1:0] instr_src1;
    logic [REG_AW-1:0] instr_src2;
    logic [DATA_W-1:0] instr_imm;
    logic              instr_stall;
    logic [REG_AW-1:0] dbg_addr;
    logic [DATA_W-1:0] dbg_data;
    logic              prf_write_enable;
    logic [REG_AW-1:0] prf_dest;
    logic [DATA_W-1:0] prf_data;

    // Sequential view of the register file
    logic [DATA_W-1:0] model [NUM_REGS];
    // Results still on their way to the register file
    logic [DATA_W-1:0] pend_data [NUM_REGS];
    logic [NUM_REGS-1:0] pend_valid;
    logic [31:0]       lfsr_state;
    int                value_errors;
    int                other_errors;
    int                accepted;
    int                write_count;
    int                last_stalls;

    exec_core #(.MUL_STAGES(MUL_STAGES)) DUT (
        .clk, .reset,
        .instr_valid, .instr_op, .instr_dest, .instr_src1, .instr_src2, .instr_imm,
        .instr_stall,
        .dbg_addr, .dbg_data,
        .prf_write_enable, .prf_dest, .prf_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(input opcode_t op_in,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
            input logic [DATA_W-1:0] imm);
        case (op_in)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_LI:   return imm;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return $signed(a) >>> b[4:0];
            default: return a * b;
        endcase
    endfunction

    // Holds the instruction until an edge accepts it, then updates the model
    task automatic issue_instr(input opcode_t op_in, input int d, input int s1, input int s2,
            input logic [DATA_W-1:0] imm);
        logic stalled;
        instr_valid = 1'b1;
        instr_op    = op_in;
        instr_dest  = REG_AW'(d);
        instr_src1  = REG_AW'(s1);
        instr_src2  = REG_AW'(s2);
        instr_imm   = imm;
        last_stalls = 0;
        do begin
            @(negedge clk);
            stalled = instr_stall;
            @(posedge clk);
            if (stalled)
                last_stalls++;
        end while (stalled);
        model[d] = expected_result(op_in, model[s1], model[s2], imm);
        pend_data[d]  = model[d];
        pend_valid[d] = 1'b1;
        accepted++;
        #2;
    endtask

    task automatic drain_pipe();
        instr_valid = 1'b0;
        repeat (MUL_STAGES + 4) @(posedge clk);
        #2;
    endtask

    task automatic check_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            dbg_addr = REG_AW'(i);
            @(negedge clk);
            assert (dbg_data === model[i]) else begin
                $display("[ERROR] dbg_data reg %0d: expected %h, got %h", i, model[i], dbg_data);
                value_errors++;
            end
            @(posedge clk);
            #2;
        end
    endtask

    // Nothing is busy after reset and the first instruction goes straight in
    task automatic check_first_issue();
        issue_instr(OP_ADD, 1, 2, 3, '0);
        assert (last_stalls == 0) else begin
            $display("The first instruction after reset was stalled");
            other_errors++;
        end
        drain_pipe();
    endtask

    task automatic run_alu_chain();
        for (int r = 0; r < NUM_REGS; r++)
            issue_instr(OP_LI, r, 0, 0, rand_bits(32));
        // Each result feeds the next instruction while opcodes cycle from ADD to XOR
        for (int i = 0; i < 30; i++)
            issue_instr(opcode_t'(i % 5), i + 2, i + 1, i, '0);
        drain_pipe();
        check_regs();
    endtask

    task automatic run_shifts();
        issue_instr(OP_LI, 1, 0, 0, 32'd0);
        issue_instr(OP_LI, 2, 0, 0, 32'd1);
        issue_instr(OP_LI, 3, 0, 0, 32'd31);
        issue_instr(OP_LI, 4, 0, 0, rand_bits(32));
        // A negative and a positive word to shift
        issue_instr(OP_LI, 10, 0, 0, 32'h8000_1234 | rand_bits(16));
        issue_instr(OP_LI, 11, 0, 0, rand_bits(31));
        for (int src = 10; src < 12; src++) begin
            for (int k = 0; k < 3; k++)
                for (int a = 1; a < 5; a++)
                    issue_instr(opcode_t'(int'(OP_SLL) + k), 12 + k * 4 + a - 1, src, a, '0);
            drain_pipe();
            check_regs();
        end
    endtask

    task automatic run_mul_chain();
        for (int r = 1; r < 9; r++)
            issue_instr(OP_LI, r, 0, 0, rand_bits(32));
        // Independent pairs keep several products in flight
        for (int i = 0; i < 4; i++)
            issue_instr(OP_MUL, 9 + i, 1 + 2 * i, 2 + 2 * i, '0);
        issue_instr(OP_MUL, 13, 9, 10, '0);
        issue_instr(OP_MUL, 14, 13, 11, '0);
        issue_instr(OP_MUL, 15, 14, 12, '0);
        drain_pipe();
        check_regs();
    endtask

    task automatic run_random_mix();
        int      writes_start;
        int      accepted_start;
        opcode_t op_r;
        writes_start   = write_count;
        accepted_start = accepted;
        for (int i = 0; i < 300; i++) begin
            op_r = opcode_t'(rand_bits(4) % 10);
            issue_instr(op_r, int'(rand_bits(5)), int'(rand_bits(5)), int'(rand_bits(5)),
                        rand_bits(32));
        end
        drain_pipe();
        assert (write_count - writes_start == accepted - accepted_start) else begin
            $display("[ERROR] prf_write_enable cycles: expected %h, got %h",
                     accepted - accepted_start, write_count - writes_start);
            value_errors++;
        end
        check_regs();
    endtask

    task automatic check_li_stall();
        issue_instr(OP_LI, 5, 0, 0, rand_bits(32));
        issue_instr(OP_ADD, 6, 5, 5, '0);
        assert (last_stalls > 0) else begin
            $display("An ADD reading a fresh LI result was accepted without any stall");
            other_errors++;
        end
        drain_pipe();
        check_regs();
    endtask

    // Every write must carry the result of an instruction still in flight
    always @(negedge clk) begin
        if (!reset && prf_write_enable) begin
            write_count++;
            assert (pend_valid[prf_dest]) else begin
                $display("A register write to reg %0d came with no instruction in flight",
                         prf_dest);
                other_errors++;
            end
            if (pend_valid[prf_dest]) begin
                assert (prf_data === pend_data[prf_dest]) else begin
                    $display("[ERROR] prf_data reg %0d: expected %h, got %h",
                             prf_dest, pend_data[prf_dest], prf_data);
                    value_errors++;
                end
            end
            pend_valid[prf_dest] = 1'b0;
        end
    end

    initial begin
        lfsr_state   = 32'h3cb0_b8ae;
        value_errors = 0;
        other_errors = 0;
        accepted     = 0;
        write_count  = 0;
        last_stalls  = 0;
        pend_valid   = '0;
        for (int i = 0; i < NUM_REGS; i++)
            model[i] = '0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_op    = OP_ADD;
        instr_dest  = '0;
        instr_src1  = '0;
        instr_src2  = '0;
        instr_imm   = '0;
        dbg_addr    = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!prf_write_enable) else begin
            $display("prf_write_enable is high right after reset");
            other_errors++;
        end
        @(posedge clk);
        #2;
        check_regs();
        check_first_issue();
        run_alu_chain();
        run_shifts();
        run_mul_chain();
        run_random_mix();
        check_li_stall();
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/exec_pkg.sv
logic/alu_unit.sv
logic/shift_unit.sv
logic/mul_unit.sv
logic/cdb.sv
logic/reg_file.sv
logic/issue_unit.sv
logic/exec_core.sv
bench/exec_core_assert.sv
bench/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the exec_core testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module exec_core_tb -o exec_core_sim || { echo "Build failed"; exit 1; }

./obj_dir/exec_core_sim > sim.log 2>&1
cat sim.log

# A missing end line also counts as a failed run
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation FAILED"; exit 1; }
echo "Simulation OK"
